//--- led_panel_pkg.sv
package led_panel_pkg;

	// panel geometry, upper and lower halves share one row pair address
	localparam int MAX_COLUMNS = 64;
	localparam int MAX_ROWS = 32;
	localparam int COLOR_W = 4;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;

	typedef logic [$clog2(MAX_COLUMNS)-1:0] col_t;
	typedef logic [$clog2(MAX_ROWS)-1:0] row_t;
	typedef logic [COLOR_W-1:0] color_t;

	// {half, row, col}, half 0 is the upper panel half
	typedef logic [$bits(row_t)+$bits(col_t):0] pixel_addr_t;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

//--- axil_pixel_slave.sv
`timescale 1ns/1ns

module axil_pixel_slave import led_panel_pkg::*; (
	input logic clk,
	input logic rst,

	// write address and write data
	input axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axi_data_t wdata,
	input logic [AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,

	// write response
	output logic bvalid,
	output axi_resp_t bresp,
	input logic bready,

	// frame buffer write port
	output logic pix_we,
	output pixel_addr_t pix_waddr,
	output color_t pix_wdata
);

	// 4 bytes per pixel, both panel halves
	localparam axi_addr_t WINDOW_BYTES = axi_addr_t'(2 * MAX_ROWS * MAX_COLUMNS * 4);

	typedef enum logic {
		IDLE,
		RESP
	} slave_state_t;

	slave_state_t state;
	logic accept;
	logic in_window;

	// address and data taken together, only while no response is pending
	assign accept = (state == IDLE) && awvalid && wvalid;
	assign in_window = (awaddr < WINDOW_BYTES);

	assign awready = accept;
	assign wready = accept;
	assign bvalid = (state == RESP);

	assign pix_we = accept && in_window && wstrb[0]; // colour sits in byte lane 0
	assign pix_waddr = awaddr[$bits(pixel_addr_t)+1:2]; // byte address to pixel index
	assign pix_wdata = wdata[COLOR_W-1:0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			bresp <= RESP_OKAY;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						state <= RESP;
						bresp <= in_window ? RESP_OKAY : RESP_SLVERR;
					end
				end
				RESP: begin
					if (bready) begin
						state <= IDLE; // response taken
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// response held until the master takes it
	assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response changed before bready");

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer import led_panel_pkg::*; (
	input logic clk,
	input logic rst,

	// write port from the bus side
	input logic pix_we,
	input pixel_addr_t pix_waddr,
	input color_t pix_wdata,

	// scan side, both halves read at once
	input logic pix_rd,
	input row_t row_addr,
	input col_t col_addr,
	output color_t rgb_top,
	output color_t rgb_bottom
);

	localparam int DEPTH = 2 * MAX_ROWS * MAX_COLUMNS;

	color_t mem [DEPTH];
	pixel_addr_t top_idx;
	pixel_addr_t bottom_idx;

	assign top_idx = {1'b0, row_addr, col_addr}; // upper half
	assign bottom_idx = {1'b1, row_addr, col_addr}; // lower half

	always_ff @(posedge clk) begin
		if (pix_we) begin
			mem[pix_waddr] <= pix_wdata;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb_top <= '0;
			rgb_bottom <= '0;
		end else if (pix_rd) begin
			rgb_top <= mem[top_idx];
			rgb_bottom <= mem[bottom_idx];
		end
	end

endmodule

//--- scan_controller.sv
`timescale 1ns/1ns

module scan_controller import led_panel_pkg::*; #(
	parameter int COLUMNS = 64,
	parameter int ROWS = 32,
	parameter int WAIT_CYCLES = 3
) (
	input logic clk,
	input logic rst,
	output row_t row_addr,
	output col_t col_addr,
	output logic pix_rd,
	output logic display_clk,
	output logic latch,
	output logic display_oe
);

	localparam int WAIT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

	typedef enum logic [2:0] {
		FETCH,
		SHIFT_HIGH,
		SHIFT_LOW,
		LATCH_HIGH,
		LATCH_LOW,
		BLANK_WAIT
	} scan_state_t;

	scan_state_t state;
	scan_state_t next_state;
	logic [WAIT_W-1:0] wait_cnt;
	logic last_col;
	logic last_row;
	logic wait_done;

	assign last_col = (col_addr == col_t'(COLUMNS - 1));
	assign last_row = (row_addr == row_t'(ROWS - 1));
	assign wait_done = (wait_cnt == WAIT_W'(WAIT_CYCLES - 1));

	// frame buffer output valid from SHIFT_HIGH on
	assign pix_rd = (state == FETCH);

	always_comb begin
		next_state = state;
		case (state)
			FETCH: next_state = SHIFT_HIGH;
			SHIFT_HIGH: next_state = SHIFT_LOW;
			SHIFT_LOW: next_state = last_col ? LATCH_HIGH : FETCH;
			LATCH_HIGH: next_state = LATCH_LOW;
			LATCH_LOW: next_state = BLANK_WAIT;
			BLANK_WAIT: next_state = wait_done ? FETCH : BLANK_WAIT;
			default: next_state = FETCH;
		endcase
	end

	// panel strobes registered from the next state, glitch free
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FETCH;
			wait_cnt <= '0;
			col_addr <= '0;
			row_addr <= '0;
			display_clk <= 1'b0;
			latch <= 1'b0;
			display_oe <= 1'b1; // dark
		end else begin
			state <= next_state;
			display_clk <= (next_state == SHIFT_LOW);
			latch <= (next_state == LATCH_HIGH) || (next_state == LATCH_LOW);
			display_oe <= (next_state != BLANK_WAIT);
			if (state == SHIFT_LOW) begin
				col_addr <= last_col ? '0 : col_addr + 1'b1;
			end
			if (state == LATCH_LOW) begin
				row_addr <= last_row ? '0 : row_addr + 1'b1;
			end
			if (state == BLANK_WAIT) begin
				wait_cnt <= wait_done ? '0 : wait_cnt + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(latch && display_clk))
		else $error("latch overlaps display_clk");

	// never lit while the row drivers take new data
	assert property (@(posedge clk) disable iff (rst) latch |-> display_oe)
		else $error("panel lit during latch");

endmodule

//--- led_panel_top.sv
`timescale 1ns/1ns

module led_panel_top import led_panel_pkg::*; #(
	parameter int COLUMNS = 64,
	parameter int ROWS = 32,
	parameter int WAIT_CYCLES = 3
) (
	input logic clk,
	input logic rst,

	// AXI4-Lite write port
	input axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axi_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic bvalid,
	output axi_resp_t bresp,
	input logic bready,

	// panel side
	output row_t row_addr,
	output col_t col_addr,
	output logic display_oe,
	output logic latch,
	output logic display_clk,
	output color_t rgb_top,
	output color_t rgb_bottom
);

	logic pix_we;
	pixel_addr_t pix_waddr;
	color_t pix_wdata;
	logic pix_rd;

	axil_pixel_slave slave_i (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.pix_we(pix_we),
		.pix_waddr(pix_waddr),
		.pix_wdata(pix_wdata)
	);

	frame_buffer fbuf_i (
		.clk(clk),
		.rst(rst),
		.pix_we(pix_we),
		.pix_waddr(pix_waddr),
		.pix_wdata(pix_wdata),
		.pix_rd(pix_rd),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom)
	);

	scan_controller #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS),
		.WAIT_CYCLES(WAIT_CYCLES)
	) scan_i (
		.clk(clk),
		.rst(rst),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.pix_rd(pix_rd),
		.display_clk(display_clk),
		.latch(latch),
		.display_oe(display_oe)
	);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- led_panel_tb.sv
`timescale 1ns/1ns

module led_panel_tb import led_panel_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_WRITES = 17;
	localparam int ROW_CYCLES = 3 * MAX_COLUMNS + 2 + 3;
	localparam int WATCHDOG_CYCLES = NUM_WRITES * 40 + 3 * MAX_ROWS * ROW_CYCLES;
	localparam int HANDSHAKE_LIMIT = 20;
	localparam int PIXELS = 2 * MAX_ROWS * MAX_COLUMNS;

	typedef struct packed {
		axi_addr_t addr;
		axi_data_t data;
		logic [3:0] strb;
		axi_resp_t resp;
		logic changes; // pixel takes the new colour
	} write_entry_t;

	logic clk;
	logic rst;
	axi_addr_t awaddr;
	logic awvalid;
	axi_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic bready;
	logic awready;
	logic wready;
	logic bvalid;
	axi_resp_t bresp;
	row_t row_addr;
	col_t col_addr;
	logic display_oe;
	logic latch;
	logic display_clk;
	color_t rgb_top;
	color_t rgb_bottom;

	write_entry_t write_table [NUM_WRITES];
	color_t shadow [PIXELS];
	logic written [PIXELS];
	int error_count;
	int check_count;
	int pixel_checks;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) clock_i (.clk(clk), .rst(rst));

	led_panel_top dut_i (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.display_oe(display_oe),
		.latch(latch),
		.display_clk(display_clk),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom)
	);

	// byte address = {half, row, col} * 4, window ends at 16 KiB
	task automatic load_table();
		write_table[0] = '{32'h0000_0000, 32'h0000_0005, 4'hf, RESP_OKAY, 1'b1}; // upper r0 c0
		write_table[1] = '{32'h0000_00fc, 32'h0000_000a, 4'hf, RESP_OKAY, 1'b1}; // upper r0 c63
		write_table[2] = '{32'h0000_2000, 32'h0000_0003, 4'hf, RESP_OKAY, 1'b1}; // lower r0 c0
		write_table[3] = '{32'h0000_20fc, 32'h1234_567c, 4'hf, RESP_OKAY, 1'b1}; // lower r0 c63
		write_table[4] = '{32'h0000_0544, 32'h0000_0007, 4'hf, RESP_OKAY, 1'b1}; // upper r5 c17
		write_table[5] = '{32'h0000_2544, 32'h0000_0009, 4'h1, RESP_OKAY, 1'b1}; // lower r5 c17
		write_table[6] = '{32'h0000_1ffc, 32'h0000_000f, 4'hf, RESP_OKAY, 1'b1}; // upper r31 c63
		write_table[7] = '{32'h0000_3f00, 32'h0000_0001, 4'hf, RESP_OKAY, 1'b1}; // lower r31 c0
		write_table[8] = '{32'h0000_1f00, 32'h0000_0006, 4'hf, RESP_OKAY, 1'b1}; // upper r31 c0
		write_table[9] = '{32'h0000_3ffc, 32'h0000_000e, 4'hf, RESP_OKAY, 1'b1}; // lower r31 c63
		write_table[10] = '{32'h0000_0ca0, 32'h0000_0002, 4'hf, RESP_OKAY, 1'b1}; // upper r12 c40
		write_table[11] = '{32'h0000_2ca0, 32'h0000_000b, 4'hf, RESP_OKAY, 1'b1}; // lower r12 c40
		write_table[12] = '{32'h0000_0544, 32'h0000_000d, 4'he, RESP_OKAY, 1'b0}; // lane 0 off
		write_table[13] = '{32'h0000_4544, 32'h0000_0008, 4'hf, RESP_SLVERR, 1'b0};
		write_table[14] = '{32'h8000_20fc, 32'h0000_0004, 4'hf, RESP_SLVERR, 1'b0};
		write_table[15] = '{32'h0000_0000, 32'hffff_fff4, 4'hf, RESP_OKAY, 1'b1}; // overwrite
		write_table[16] = '{32'h0000_2ca0, 32'h0000_0000, 4'h1, RESP_OKAY, 1'b1};
	endtask

	task automatic value_error(input string msg);
		error_count++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	task automatic update_shadow(input write_entry_t e);
		logic [11:0] idx;
		idx = e.addr[13:2];
		if (e.changes) begin
			shadow[idx] = e.data[COLOR_W-1:0];
			written[idx] = 1'b1;
		end
	endtask

	task automatic present_write(input int i);
		awaddr <= write_table[i].addr;
		wdata <= write_table[i].data;
		wstrb <= write_table[i].strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
	endtask

	task automatic check_reset_state();
		check_count++;
		if (display_oe !== 1'b1 || latch !== 1'b0 || display_clk !== 1'b0 || row_addr !== '0
			|| col_addr !== '0 || awready !== 1'b0 || wready !== 1'b0 || bvalid !== 1'b0) begin
			value_error($sformatf("reset state oe=%b latch=%b dclk=%b row=%0d col=%0d aw=%b w=%b b=%b",
				display_oe, latch, display_clk, row_addr, col_addr, awready, wready, bvalid));
		end
	endtask

	// next write is presented while the previous response is still held
	task automatic run_writes();
		int next;
		int silent;
		int stall;
		logic pending;
		logic accepted;
		axi_resp_t exp_resp;
		next = 0;
		silent = 0;
		stall = 0;
		pending = 1'b0;
		exp_resp = RESP_OKAY;
		@(posedge clk);
		present_write(0);
		while ((next < NUM_WRITES || pending) && silent < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			silent++;
			accepted = awready && wready;
			if (pending) begin
				check_count++;
				if (bvalid !== 1'b1 || bresp !== exp_resp || awready !== 1'b0 || wready !== 1'b0) begin
					value_error($sformatf("write %0d bvalid=%b bresp=%0d aw=%b w=%b, want bresp %0d",
						next - 1, bvalid, bresp, awready, wready, exp_resp));
				end
				if (bvalid && bready) begin
					pending = 1'b0;
					silent = 0;
				end
			end else if (bvalid !== 1'b0) begin
				value_error("bvalid high with no write outstanding");
			end
			if (accepted && next < NUM_WRITES) begin
				exp_resp = write_table[next].resp;
				update_shadow(write_table[next]);
				stall = int'($urandom % 6);
				pending = 1'b1;
				next++;
				silent = 0;
			end
			@(posedge clk);
			if (accepted && next < NUM_WRITES) begin
				present_write(next);
			end else if (accepted) begin
				awvalid <= 1'b0;
				wvalid <= 1'b0;
			end
			if (pending && stall == 0) begin
				bready <= 1'b1;
			end else begin
				bready <= 1'b0;
				if (pending) stall--;
			end
		end
		if (silent >= HANDSHAKE_LIMIT) begin
			error_count++;
			$display("no write handshake for %0d cycles, writes stopped", HANDSHAKE_LIMIT);
		end
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b0;
	endtask

	task automatic check_pixels();
		pixel_addr_t top_idx;
		pixel_addr_t bottom_idx;
		top_idx = {1'b0, row_addr, col_addr};
		bottom_idx = {1'b1, row_addr, col_addr};
		if (written[top_idx]) begin
			pixel_checks++;
			check_count++;
			if (rgb_top !== shadow[top_idx]) begin
				value_error($sformatf("row %0d col %0d upper colour %h, expected %h",
					row_addr, col_addr, rgb_top, shadow[top_idx]));
			end
		end
		if (written[bottom_idx]) begin
			pixel_checks++;
			check_count++;
			if (rgb_bottom !== shadow[bottom_idx]) begin
				value_error($sformatf("row %0d col %0d lower colour %h, expected %h",
					row_addr, col_addr, rgb_bottom, shadow[bottom_idx]));
			end
		end
	endtask

	task automatic watch_rows(input int n_rows);
		row_t exp_row;
		int pulses;
		int latch_len;
		int lit_len;
		@(negedge clk);
		while (display_oe) @(negedge clk);
		while (!display_oe) @(negedge clk); // now at column 0 of a row
		exp_row = row_addr;
		for (int r = 0; r < n_rows; r++) begin
			pulses = 0;
			latch_len = 0;
			lit_len = 0;
			while (!latch) begin
				if (!display_oe) lit_len++;
				if (display_clk) begin
					check_count++;
					if (col_addr !== col_t'(pulses) || row_addr !== exp_row) begin
						value_error($sformatf("shift at row %0d col %0d, expected row %0d col %0d",
							row_addr, col_addr, exp_row, pulses));
					end
					check_pixels();
					pulses++;
				end
				@(negedge clk);
			end
			while (latch) begin
				latch_len++;
				@(negedge clk);
			end
			exp_row = (exp_row == row_t'(MAX_ROWS - 1)) ? '0 : exp_row + 1'b1;
			check_count++;
			if (row_addr !== exp_row) begin
				value_error($sformatf("row_addr %0d after latch, expected %0d", row_addr, exp_row));
			end
			while (!display_oe) begin
				lit_len++;
				@(negedge clk);
			end
			check_count++;
			if (pulses != MAX_COLUMNS || latch_len != 2 || lit_len != 3) begin
				value_error($sformatf("row timing %0d shifts, latch %0d, lit %0d cycles",
					pulses, latch_len, lit_len));
			end
		end
	endtask

	initial begin
		int written_count;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		error_count = 0;
		check_count = 0;
		pixel_checks = 0;
		written_count = 0;
		void'($urandom(21150));
		load_table();
		for (int i = 0; i < PIXELS; i++) begin
			shadow[i] = '0;
			written[i] = 1'b0;
		end
		do begin
			@(negedge clk);
			check_reset_state();
		end while (rst);
		run_writes();
		for (int i = 0; i < PIXELS; i++) begin
			if (written[i]) written_count++;
		end
		watch_rows(2 * MAX_ROWS); // two full frames
		check_count++;
		if (pixel_checks != 2 * written_count) begin
			error_count++;
			$display("the scan showed written pixels %0d times instead of %0d",
				pixel_checks, 2 * written_count);
		end
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("simulation still running after %0d cycles, stopped by the watchdog",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

//--- sources.f
led_panel_pkg.sv
axil_pixel_slave.sv
frame_buffer.sv
scan_controller.sv
led_panel_top.sv
tb_clock_gen.sv
led_panel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module led_panel_tb -f sources.f \
	&& ./obj_dir/Vled_panel_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
